//--- hw/axi_bridge_pkg.sv
`default_nettype none

package axi_bridge_pkg;

	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 32;
	localparam int LINE_BEATS = 16;
	localparam int STRB_W     = DATA_W / 8;
	localparam int ID_W       = 4;  // AXI id field, only bit 0 carries meaning
	localparam int LEN_W      = 4;
	localparam int SIZE_W     = 3;
	localparam int RESP_W     = 2;
	localparam int LINE_OFF   = $clog2(LINE_BEATS * STRB_W);  // byte offset bits inside a line

	localparam logic ID_ICACHE = 1'b0;
	localparam logic ID_DCACHE = 1'b1;

	localparam logic [1:0]       BURST_INCR = 2'b01;
	localparam logic [LEN_W-1:0] LINE_LEN   = LEN_W'(LINE_BEATS - 1);

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] word_t;
	typedef logic [LINE_BEATS-1:0][DATA_W-1:0] line_t;  // word 0 in the low bits

	typedef struct packed {
		addr_t             addr;
		logic [SIZE_W-1:0] size;
	} cache_rd_req_t;

	typedef struct packed {
		word_t data;
		logic  last;
	} cache_ret_t;

	typedef struct packed {
		addr_t             addr;
		logic [SIZE_W-1:0] size;
		logic [STRB_W-1:0] strb;
		line_t             line;
	} cache_wr_req_t;

	// AR and AW share one layout
	typedef struct packed {
		logic [ID_W-1:0]   id;
		addr_t             addr;
		logic [LEN_W-1:0]  len;
		logic [SIZE_W-1:0] size;
		logic [1:0]        burst;
	} axi_ax_t;

	typedef axi_ax_t axi_ar_t;
	typedef axi_ax_t axi_aw_t;

	typedef struct packed {
		word_t             data;
		logic [STRB_W-1:0] strb;
		logic              last;
	} axi_w_t;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		word_t             data;
		logic [RESP_W-1:0] resp;
		logic              last;
	} axi_r_t;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [RESP_W-1:0] resp;
	} axi_b_t;

endpackage

`default_nettype wire

//--- hw/beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

module beat_counter #(
	parameter int LINE_BEATS = axi_bridge_pkg::LINE_BEATS
) (
	input  wire  clk,
	input  wire  rst,
	input  wire  clear,
	input  wire  count_en,
	output logic last_beat
);

	localparam int CNT_W = (LINE_BEATS > 1) ? $clog2(LINE_BEATS) : 1;

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (!rst) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (count_en) begin
			// wrap after the last beat so the next burst starts at 0
			count <= last_beat ? '0 : count + 1'b1;
		end
	end

	assign last_beat = (count == CNT_W'(LINE_BEATS - 1));

endmodule

`default_nettype wire

//--- hw/wb_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module wb_buffer #(
	parameter int LINE_BEATS = axi_bridge_pkg::LINE_BEATS
) (
	input  wire                                clk,
	input  wire                                rst,
	input  wire                                load,
	input  wire                                shift,
	input  wire axi_bridge_pkg::cache_wr_req_t dc_wr,
	output axi_bridge_pkg::axi_aw_t            aw,
	output axi_bridge_pkg::word_t              w_data,
	output logic [axi_bridge_pkg::STRB_W-1:0]  w_strb,
	output axi_bridge_pkg::addr_t              pend_line
);

	localparam int DATA_W = axi_bridge_pkg::DATA_W;
	localparam int ID_W   = axi_bridge_pkg::ID_W;
	localparam int LEN_W  = axi_bridge_pkg::LEN_W;
	localparam logic [LEN_W-1:0] BURST_LEN = LEN_W'(LINE_BEATS - 1);

	logic [LINE_BEATS-1:0][DATA_W-1:0]       line_q;
	axi_bridge_pkg::addr_t                   addr_q;
	logic [axi_bridge_pkg::SIZE_W-1:0]       size_q;
	logic [axi_bridge_pkg::STRB_W-1:0]       strb_q;

	// pending line address for the read hazard check
	always_ff @(posedge clk) begin
		if (!rst) begin
			addr_q <= '0;
		end else if (load) begin
			addr_q <= dc_wr.addr;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			line_q <= dc_wr.line;
			size_q <= dc_wr.size;
			strb_q <= dc_wr.strb;
		end else if (shift) begin
			line_q <= {{DATA_W{1'b0}}, line_q[LINE_BEATS-1:1]};  // next word into slot 0
		end
	end

	assign aw.id    = {{(ID_W-1){1'b0}}, axi_bridge_pkg::ID_DCACHE};
	assign aw.addr  = addr_q;
	assign aw.len   = BURST_LEN;
	assign aw.size  = size_q;
	assign aw.burst = axi_bridge_pkg::BURST_INCR;

	assign w_data    = line_q[0];
	assign w_strb    = strb_q;
	assign pend_line = addr_q;

endmodule

`default_nettype wire

//--- hw/wr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wr_ctrl (
	input  wire  clk,
	input  wire  rst,
	input  wire  dc_wr_req,
	output logic dc_wr_rdy,
	output logic awvalid,
	input  wire  awready,
	output logic wvalid,
	input  wire  wready,
	input  wire  bvalid,
	output logic bready,
	input  wire  last_beat,
	output logic load,
	output logic shift,
	output logic count_en,
	output logic clear,
	output logic wr_busy
);

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	wr_state_e state;
	wr_state_e state_nxt;
	logic      beat_ok;

	assign beat_ok = (state == WR_DATA) && wready;  // one W beat accepted

	always_comb begin
		state_nxt = state;
		case (state)
			WR_IDLE: begin
				if (dc_wr_req) begin
					state_nxt = WR_ADDR;
				end
			end
			WR_ADDR: begin
				if (awready) begin
					state_nxt = WR_DATA;
				end
			end
			WR_DATA: begin
				// leave on the accepted last beat only
				if (beat_ok && last_beat) begin
					state_nxt = WR_RESP;
				end
			end
			WR_RESP: begin
				if (bvalid) begin
					state_nxt = WR_IDLE;
				end
			end
			default: state_nxt = WR_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= WR_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign dc_wr_rdy = (state == WR_IDLE);
	assign load      = dc_wr_req && dc_wr_rdy;
	assign clear     = load;     // fresh count per writeback
	assign awvalid   = (state == WR_ADDR);
	assign wvalid    = (state == WR_DATA);
	assign shift     = beat_ok;
	assign count_en  = beat_ok;  // stalls with wready low
	assign bready    = 1'b1;
	assign wr_busy   = (state != WR_IDLE);

endmodule

`default_nettype wire

//--- hw/rd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rd_ctrl (
	input  wire                                clk,
	input  wire                                rst,
	input  wire                                ic_rd_req,
	input  wire axi_bridge_pkg::cache_rd_req_t ic_rd,
	output logic                               ic_rd_rdy,
	input  wire                                dc_rd_req,
	input  wire axi_bridge_pkg::cache_rd_req_t dc_rd,
	output logic                               dc_rd_rdy,
	output logic                               ic_ret_valid,
	output axi_bridge_pkg::cache_ret_t         ic_ret,
	output logic                               dc_ret_valid,
	output axi_bridge_pkg::cache_ret_t         dc_ret,
	output axi_bridge_pkg::axi_ar_t            ar,
	output logic                               arvalid,
	input  wire                                arready,
	input  wire axi_bridge_pkg::axi_r_t        r,
	input  wire                                rvalid,
	output logic                               rready,
	input  wire                                wr_busy,
	input  wire axi_bridge_pkg::addr_t         pend_line
);

	localparam int AW   = axi_bridge_pkg::ADDR_W;
	localparam int OFF  = axi_bridge_pkg::LINE_OFF;
	localparam int ID_W = axi_bridge_pkg::ID_W;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_REQ,
		RD_RESP
	} rd_state_e;

	rd_state_e                   state;
	rd_state_e                   state_nxt;
	axi_bridge_pkg::axi_ar_t     ar_q;
	axi_bridge_pkg::axi_ar_t     ar_nxt;
	axi_bridge_pkg::cache_ret_t  ret_word;
	logic                        ic_hit;
	logic                        dc_hit;
	logic                        ic_take;
	logic                        dc_take;
	logic                        rid_dc;

	// same line as a writeback still in flight
	assign ic_hit = wr_busy && (ic_rd.addr[AW-1:OFF] == pend_line[AW-1:OFF]);
	assign dc_hit = wr_busy && (dc_rd.addr[AW-1:OFF] == pend_line[AW-1:OFF]);

	assign ic_rd_rdy = (state == RD_IDLE) && !ic_hit;
	assign dc_rd_rdy = (state == RD_IDLE) && !dc_hit && !ic_rd_req;  // icache goes first

	assign ic_take = ic_rd_req && ic_rd_rdy;
	assign dc_take = dc_rd_req && dc_rd_rdy;

	always_comb begin
		ar_nxt.id    = {{(ID_W-1){1'b0}}, ic_take ? axi_bridge_pkg::ID_ICACHE
			: axi_bridge_pkg::ID_DCACHE};
		ar_nxt.addr  = ic_take ? ic_rd.addr : dc_rd.addr;
		ar_nxt.size  = ic_take ? ic_rd.size : dc_rd.size;
		ar_nxt.len   = axi_bridge_pkg::LINE_LEN;
		ar_nxt.burst = axi_bridge_pkg::BURST_INCR;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			RD_IDLE: begin
				if (ic_take || dc_take) begin
					state_nxt = RD_REQ;
				end
			end
			RD_REQ: begin
				if (arready) begin
					state_nxt = RD_RESP;
				end
			end
			RD_RESP: begin
				if (rvalid && r.last) begin
					state_nxt = RD_IDLE;
				end
			end
			default: state_nxt = RD_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= RD_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// request held stable while arvalid waits
	always_ff @(posedge clk) begin
		if (ic_take || dc_take) begin
			ar_q <= ar_nxt;
		end
	end

	assign ar      = ar_q;
	assign arvalid = (state == RD_REQ);
	assign rready  = 1'b1;

	// beats go straight through, steered by rid
	assign rid_dc       = (r.id == {{(ID_W-1){1'b0}}, axi_bridge_pkg::ID_DCACHE});
	assign ret_word     = '{data: r.data, last: r.last};
	assign ic_ret       = ret_word;
	assign dc_ret       = ret_word;
	assign ic_ret_valid = (state == RD_RESP) && rvalid && !rid_dc;
	assign dc_ret_valid = (state == RD_RESP) && rvalid && rid_dc;

endmodule

`default_nettype wire

//--- hw/axi_cache_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axi_cache_bridge #(
	parameter int LINE_BEATS = axi_bridge_pkg::LINE_BEATS
) (
	input  wire                           clk,
	input  wire                           rst,
	// cache read ports
	input  wire                           ic_rd_req,
	input  wire                           dc_rd_req,
	input  wire axi_bridge_pkg::cache_rd_req_t ic_rd,
	input  wire axi_bridge_pkg::cache_rd_req_t dc_rd,
	output logic                          ic_rd_rdy,
	output logic                          dc_rd_rdy,
	output logic                          ic_ret_valid,
	output logic                          dc_ret_valid,
	output axi_bridge_pkg::cache_ret_t    ic_ret,
	output axi_bridge_pkg::cache_ret_t    dc_ret,
	// dcache writeback port
	input  wire                           dc_wr_req,
	input  wire axi_bridge_pkg::cache_wr_req_t dc_wr,
	output logic                          dc_wr_rdy,
	// AXI master
	output axi_bridge_pkg::axi_ar_t       ar,
	output logic                          arvalid,
	input  wire                           arready,
	input  wire axi_bridge_pkg::axi_r_t   r,
	input  wire                           rvalid,
	output logic                          rready,
	output axi_bridge_pkg::axi_aw_t       aw,
	output logic                          awvalid,
	input  wire                           awready,
	output axi_bridge_pkg::axi_w_t        w,
	output logic                          wvalid,
	input  wire                           wready,
	input  wire axi_bridge_pkg::axi_b_t   b,
	input  wire                           bvalid,
	output logic                          bready
);

	logic                                      wr_busy;
	axi_bridge_pkg::addr_t                     pend_line;
	logic                                      load;
	logic                                      shift;
	logic                                      count_en;
	logic                                      clear;
	logic                                      last_beat;
	axi_bridge_pkg::word_t                     w_data;
	logic [axi_bridge_pkg::STRB_W-1:0]         w_strb;

	rd_ctrl i_rd_ctrl (
		.clk          (clk),
		.rst          (rst),
		.ic_rd_req    (ic_rd_req),
		.ic_rd        (ic_rd),
		.ic_rd_rdy    (ic_rd_rdy),
		.dc_rd_req    (dc_rd_req),
		.dc_rd        (dc_rd),
		.dc_rd_rdy    (dc_rd_rdy),
		.ic_ret_valid (ic_ret_valid),
		.ic_ret       (ic_ret),
		.dc_ret_valid (dc_ret_valid),
		.dc_ret       (dc_ret),
		.ar           (ar),
		.arvalid      (arvalid),
		.arready      (arready),
		.r            (r),
		.rvalid       (rvalid),
		.rready       (rready),
		.wr_busy      (wr_busy),
		.pend_line    (pend_line)
	);

	wr_ctrl i_wr_ctrl (
		.clk       (clk),
		.rst       (rst),
		.dc_wr_req (dc_wr_req),
		.dc_wr_rdy (dc_wr_rdy),
		.awvalid   (awvalid),
		.awready   (awready),
		.wvalid    (wvalid),
		.wready    (wready),
		.bvalid    (bvalid),
		.bready    (bready),
		.last_beat (last_beat),
		.load      (load),
		.shift     (shift),
		.count_en  (count_en),
		.clear     (clear),
		.wr_busy   (wr_busy)
	);

	beat_counter #(.LINE_BEATS(LINE_BEATS)) i_beat_counter (
		.clk       (clk),
		.rst       (rst),
		.clear     (clear),
		.count_en  (count_en),
		.last_beat (last_beat)
	);

	wb_buffer #(.LINE_BEATS(LINE_BEATS)) i_wb_buffer (
		.clk       (clk),
		.rst       (rst),
		.load      (load),
		.shift     (shift),
		.dc_wr     (dc_wr),
		.aw        (aw),
		.w_data    (w_data),
		.w_strb    (w_strb),
		.pend_line (pend_line)
	);

	assign w = '{data: w_data, strb: w_strb, last: last_beat};  // counter sits at 0 outside a burst

endmodule

`default_nettype wire

//--- dv/axi_cache_bridge_assert.sv
`timescale 1ns/1ps
`default_nettype none

module axi_cache_bridge_assert (
	input wire                          clk,
	input wire                          rst,
	input wire axi_bridge_pkg::axi_ar_t ar,
	input wire                          arvalid,
	input wire                          arready,
	input wire axi_bridge_pkg::axi_aw_t aw,
	input wire                          awvalid,
	input wire                          awready,
	input wire axi_bridge_pkg::axi_w_t  w,
	input wire                          wvalid,
	input wire                          wready,
	input wire                          ic_ret_valid,
	input wire                          dc_ret_valid
);

	// a raised valid keeps its payload until the slave takes it
	ar_hold: assert property (@(posedge clk) disable iff (!rst)
		arvalid && !arready |=> arvalid && $stable(ar))
		else $error("AR valid or payload changed before arready");

	aw_hold: assert property (@(posedge clk) disable iff (!rst)
		awvalid && !awready |=> awvalid && $stable(aw))
		else $error("AW valid or payload changed before awready");

	w_hold: assert property (@(posedge clk) disable iff (!rst)
		wvalid && !wready |=> wvalid && $stable(w))
		else $error("W valid or payload changed before wready");

	wlast_only_valid: assert property (@(posedge clk) disable iff (!rst)
		w.last |-> wvalid)
		else $error("wlast seen without wvalid");

	one_return: assert property (@(posedge clk) disable iff (!rst)
		!(ic_ret_valid && dc_ret_valid))
		else $error("both caches got a return beat in one cycle");

endmodule

`default_nettype wire

//--- dv/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
	input  wire                          clk,
	input  wire                          rst,
	input  wire axi_bridge_pkg::axi_ar_t ar,
	input  wire                          arvalid,
	output logic                         arready,
	output axi_bridge_pkg::axi_r_t       r,
	output logic                         rvalid,
	input  wire                          rready,
	input  wire axi_bridge_pkg::axi_aw_t aw,
	input  wire                          awvalid,
	output logic                         awready,
	input  wire axi_bridge_pkg::axi_w_t  w,
	input  wire                          wvalid,
	output logic                         wready,
	output axi_bridge_pkg::axi_b_t       b,
	output logic                         bvalid,
	input  wire                          bready
);

	axi_bridge_pkg::word_t mem [logic [29:0]];  // only written words live here
	logic [31:0]           lfsr;
	axi_bridge_pkg::addr_t rd_addr;
	axi_bridge_pkg::addr_t wr_addr;
	logic [3:0]            rd_id;
	int                    rd_left;
	logic                  b_pend;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic take_bit();
		logic bit_out;
		bit_out = lfsr[31];
		lfsr = lfsr_step(lfsr);
		return bit_out;
	endfunction

	function automatic axi_bridge_pkg::word_t read_word(input axi_bridge_pkg::addr_t a);
		if (mem.exists(a[31:2])) begin
			return mem[a[31:2]];
		end
		return {2'b00, a[31:2]} ^ 32'h5a5a_0000;  // fill from the word address
	endfunction

	initial begin
		lfsr    = 32'hc7c1_1480;
		rd_addr = '0;
		wr_addr = '0;
		rd_id   = '0;
		rd_left = 0;
		b_pend  = 1'b0;
		arready = 1'b0;
		awready = 1'b0;
		wready  = 1'b0;
		rvalid  = 1'b0;
		bvalid  = 1'b0;
		r       = '0;
		b       = '0;
		forever begin
			@(posedge clk);
			if (!rst) begin
				rd_left = 0;
				b_pend  = 1'b0;
			end else begin
				if (rvalid && rready) begin
					rd_addr = rd_addr + 32'd4;
					rd_left = rd_left - 1;
				end
				if (arvalid && arready) begin
					rd_addr = ar.addr;
					rd_id   = ar.id;
					rd_left = int'(ar.len) + 1;
				end
				if (awvalid && awready) begin
					wr_addr = aw.addr;
				end
				if (bvalid && bready) begin
					b_pend = 1'b0;
				end
				if (wvalid && wready) begin
					mem[wr_addr[31:2]] = w.data;
					wr_addr = wr_addr + 32'd4;
					b_pend  = b_pend | w.last;  // respond once the burst is in
				end
			end
			#1;
			arready = take_bit();
			awready = take_bit();
			wready  = take_bit();
			rvalid  = (rd_left != 0);
			r       = '{id: rd_id, data: read_word(rd_addr), resp: 2'b00, last: (rd_left == 1)};
			bvalid  = b_pend;
			b       = '{id: 4'h1, resp: 2'b00};
		end
	end

endmodule

`default_nettype wire

//--- dv/tb_axi_cache_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_cache_bridge;

	localparam int BEATS      = 16;
	localparam int TIMEOUT    = 1000;  // cycles per wait

	logic                          clk;
	logic                          rst;
	logic                          ic_rd_req;
	logic                          dc_rd_req;
	axi_bridge_pkg::cache_rd_req_t ic_rd;
	axi_bridge_pkg::cache_rd_req_t dc_rd;
	logic                          ic_rd_rdy;
	logic                          dc_rd_rdy;
	logic                          ic_ret_valid;
	logic                          dc_ret_valid;
	axi_bridge_pkg::cache_ret_t    ic_ret;
	axi_bridge_pkg::cache_ret_t    dc_ret;
	logic                          dc_wr_req;
	axi_bridge_pkg::cache_wr_req_t dc_wr;
	logic                          dc_wr_rdy;
	axi_bridge_pkg::axi_ar_t       ar;
	logic                          arvalid;
	logic                          arready;
	axi_bridge_pkg::axi_r_t        r;
	logic                          rvalid;
	logic                          rready;
	axi_bridge_pkg::axi_aw_t       aw;
	logic                          awvalid;
	logic                          awready;
	axi_bridge_pkg::axi_w_t        w;
	logic                          wvalid;
	logic                          wready;
	axi_bridge_pkg::axi_b_t        b;
	logic                          bvalid;
	logic                          bready;

	axi_bridge_pkg::word_t line_seed [logic [25:0]];  // written lines by line address
	time                   b_time;

	axi_cache_bridge #(.LINE_BEATS(BEATS)) i_axi_cache_bridge (.*);

	axi_mem_model i_axi_mem_model (.*);

	bind axi_cache_bridge axi_cache_bridge_assert i_bridge_assert (
		.clk          (clk),
		.rst          (rst),
		.ar           (ar),
		.arvalid      (arvalid),
		.arready      (arready),
		.aw           (aw),
		.awvalid      (awvalid),
		.awready      (awready),
		.w            (w),
		.wvalid       (wvalid),
		.wready       (wready),
		.ic_ret_valid (ic_ret_valid),
		.dc_ret_valid (dc_ret_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per data bit, word 0 first
	function automatic axi_bridge_pkg::line_t make_line(input logic [31:0] seed);
		axi_bridge_pkg::line_t l;
		logic [31:0]           s;
		int                    i;
		int                    k;
		s = seed;
		for (i = 0; i < BEATS; i++) begin
			for (k = 0; k < 32; k++) begin
				l[i][k] = s[31];
				s = lfsr_step(s);
			end
		end
		return l;
	endfunction

	function automatic axi_bridge_pkg::line_t expected_line(input axi_bridge_pkg::addr_t addr);
		axi_bridge_pkg::line_t l;
		axi_bridge_pkg::addr_t a;
		int                    i;
		if (line_seed.exists(addr[31:6])) begin
			return make_line(line_seed[addr[31:6]]);
		end
		for (i = 0; i < BEATS; i++) begin
			a = addr + 32'(i * 4);
			l[i] = {2'b00, a[31:2]} ^ 32'h5a5a_0000;
		end
		return l;
	endfunction

	task automatic read_line(input logic dcache, input axi_bridge_pkg::addr_t addr,
			input logic has_exp, input logic [31:0] exp0, output time accept_t, output time done_t);
		axi_bridge_pkg::line_t      exp;
		axi_bridge_pkg::cache_ret_t ret;
		logic                       got_valid;
		logic                       other_valid;
		int                         t;
		int                         beat;
		@(posedge clk);
		#1;
		if (dcache) begin
			dc_rd_req = 1'b1;
			dc_rd     = '{addr: addr, size: 3'd2};
		end else begin
			ic_rd_req = 1'b1;
			ic_rd     = '{addr: addr, size: 3'd2};
		end
		t = 0;
		@(posedge clk);
		while (!(dcache ? dc_rd_rdy : ic_rd_rdy)) begin
			t++;
			if (t > TIMEOUT) fail_run($sformatf("timeout waiting for read of %h to be taken", addr));
			@(posedge clk);
		end
		accept_t = $time;
		exp = expected_line(addr);  // the line as it stands when the read is taken
		if (has_exp) check("word 0 vs stimulus file", exp[0], exp0);
		#1;
		if (dcache) dc_rd_req = 1'b0;
		else ic_rd_req = 1'b0;
		t = 0;
		@(posedge clk);
		while (!(arvalid && arready)) begin
			t++;
			if (t > TIMEOUT) fail_run($sformatf("timeout waiting for arready on %h", addr));
			@(posedge clk);
		end
		check("ar.addr", ar.addr, addr);
		check("ar.id", 32'(ar.id), 32'(dcache));
		check("ar.len", 32'(ar.len), 32'(BEATS - 1));
		check("ar.burst", 32'(ar.burst), 32'h1);
		check("ar.size", 32'(ar.size), 32'h2);
		beat = 0;
		t = 0;
		while (beat < BEATS) begin
			@(posedge clk);
			got_valid   = dcache ? dc_ret_valid : ic_ret_valid;
			other_valid = dcache ? ic_ret_valid : dc_ret_valid;
			ret         = dcache ? dc_ret : ic_ret;
			check(dcache ? "ic_ret_valid" : "dc_ret_valid", 32'(other_valid), 32'h0);
			if (got_valid) begin
				check(dcache ? "dc_ret.data" : "ic_ret.data", ret.data, exp[beat]);
				check(dcache ? "dc_ret.last" : "ic_ret.last", 32'(ret.last), 32'(beat == BEATS - 1));
				beat++;
				t = 0;
			end else begin
				t++;
				if (t > TIMEOUT) fail_run($sformatf("timeout waiting for beat %0d of %h", beat, addr));
			end
		end
		done_t = $time;
	endtask

	task automatic writeback(input axi_bridge_pkg::addr_t addr, input logic [31:0] seed,
			input logic [31:0] exp0);
		axi_bridge_pkg::line_t line;
		int                    t;
		int                    beat;
		line = make_line(seed);
		check("W word 0 vs stimulus file", line[0], exp0);
		@(posedge clk);
		#1;
		dc_wr_req = 1'b1;
		dc_wr     = '{addr: addr, size: 3'd2, strb: 4'hf, line: line};
		t = 0;
		@(posedge clk);
		while (!dc_wr_rdy) begin
			t++;
			if (t > TIMEOUT) fail_run("timeout waiting for dc_wr_rdy");
			@(posedge clk);
		end
		#1;
		dc_wr_req = 1'b0;
		t = 0;
		@(posedge clk);
		while (!(awvalid && awready)) begin
			t++;
			if (t > TIMEOUT) fail_run("timeout waiting for the AW handshake");
			@(posedge clk);
		end
		check("aw.addr", aw.addr, addr);
		check("aw.id", 32'(aw.id), 32'h1);
		check("aw.len", 32'(aw.len), 32'(BEATS - 1));
		check("aw.burst", 32'(aw.burst), 32'h1);
		check("aw.size", 32'(aw.size), 32'h2);
		beat = 0;
		t = 0;
		while (beat < BEATS) begin
			@(posedge clk);
			if (wvalid && wready) begin
				check("w.data", w.data, line[beat]);
				check("w.strb", 32'(w.strb), 32'hf);
				check("w.last", 32'(w.last), 32'(beat == BEATS - 1));
				beat++;
				t = 0;
			end else begin
				t++;
				if (t > TIMEOUT) fail_run($sformatf("timeout waiting for W beat %0d", beat));
			end
		end
		t = 0;
		@(posedge clk);
		while (!(bvalid && bready)) begin
			t++;
			if (t > TIMEOUT) fail_run("timeout waiting for the write response");
			@(posedge clk);
		end
		b_time = $time;
		line_seed[addr[31:6]] = seed;  // memory holds the new line from here on
		t = 0;
		@(posedge clk);
		while (!dc_wr_rdy) begin
			t++;
			if (t > TIMEOUT) fail_run("timeout waiting for dc_wr_rdy after the response");
			@(posedge clk);
		end
	endtask

	initial begin
		string       line_s;
		int          fd;
		int          n;
		int          n_cmds;
		logic [31:0] cmd;
		logic [31:0] addr_a;
		logic [31:0] addr_b;
		logic [31:0] seed;
		logic [31:0] word0;
		time         acc_a;
		time         acc_b;
		time         done_a;
		time         done_b;
		rst       = 1'b0;
		ic_rd_req = 1'b0;
		dc_rd_req = 1'b0;
		ic_rd     = '0;
		dc_rd     = '0;
		dc_wr_req = 1'b0;
		dc_wr     = '0;
		b_time    = 0;
		n_cmds    = 0;
		repeat (4) @(posedge clk);
		#1 rst = 1'b1;
		@(posedge clk);
		check("arvalid", 32'(arvalid), 32'h0);
		check("awvalid", 32'(awvalid), 32'h0);
		check("wvalid", 32'(wvalid), 32'h0);
		check("ic_ret_valid", 32'(ic_ret_valid), 32'h0);
		check("dc_ret_valid", 32'(dc_ret_valid), 32'h0);
		check("ic_rd_rdy", 32'(ic_rd_rdy), 32'h1);
		check("dc_rd_rdy", 32'(dc_rd_rdy), 32'h1);
		check("dc_wr_rdy", 32'(dc_wr_rdy), 32'h1);
		fd = $fopen("dv/bridge_stimulus.txt", "r");
		if (fd == 0) fail_run("cannot open dv/bridge_stimulus.txt");
		while ($fgets(line_s, fd) != 0) begin
			n = $sscanf(line_s, "%h %h %h %h %h", cmd, addr_a, addr_b, seed, word0);
			if (n == 5) begin  // comment and blank lines scan nothing
				n_cmds++;
				case (cmd)
					32'd1: read_line(1'b0, addr_a, 1'b1, word0, acc_a, done_a);
					32'd2: read_line(1'b1, addr_a, 1'b1, word0, acc_a, done_a);
					32'd3: begin
						fork
							read_line(1'b0, addr_a, 1'b1, word0, acc_a, done_a);
							read_line(1'b1, addr_b, 1'b0, 32'h0, acc_b, done_b);
						join
						check("icache refill done first", 32'(done_a < done_b), 32'h1);
					end
					32'd4: writeback(addr_a, seed, word0);
					32'd5: begin
						fork
							writeback(addr_a, seed, word0);
							read_line(1'b0, addr_b, 1'b0, 32'h0, acc_b, done_b);
							begin
								repeat (2) @(posedge clk);
								read_line(1'b1, addr_a, 1'b1, word0, acc_a, done_a);
							end
						join
						check("dcache read taken after bresp", 32'(acc_a > b_time), 32'h1);
					end
					default: fail_run($sformatf("unknown command %0h in stimulus file", cmd));
				endcase
			end else if (n > 0) begin
				fail_run("malformed line in stimulus file");
			end
		end
		$fclose(fd);
		if (n_cmds == 0) fail_run("stimulus file holds no commands");
		repeat (4) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
hw/axi_bridge_pkg.sv
hw/beat_counter.sv
hw/wb_buffer.sv
hw/wr_ctrl.sv
hw/rd_ctrl.sv
hw/axi_cache_bridge.sv
dv/axi_cache_bridge_assert.sv
dv/axi_mem_model.sv
dv/tb_axi_cache_bridge.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_cache_bridge
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the pass line in the output decides the status
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/bridge_stimulus.txt
# cmd addr_a addr_b seed word0, all hex; cmd 1 icache read, 2 dcache read, 3 both reads
# 4 writeback, 5 writeback with reads of addr_a and addr_b; word0 is the first word at addr_a
1 00001000 00000000 00000000 5a5a0400
2 00002000 00000000 00000000 5a5a0800
4 00003040 00000000 12345678 1e6a2c48
2 00003040 00000000 00000000 1e6a2c48
1 00003040 00000000 00000000 1e6a2c48
3 00004000 00003040 00000000 5a5a1000
5 00006000 00007000 8badf00d b00fb5d1
2 00006000 00000000 00000000 b00fb5d1
4 00001000 00000000 a5a5c3c3 c3c3a5a5
1 00001000 00000000 00000000 c3c3a5a5
5 00008000 00001000 00000001 80000000
3 00008000 00009000 00000000 80000000
2 00007000 00000000 00000000 5a5a1c00
